// ==== verilog/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam logic [31:0] RESET_PC = 32'haaaaa000;

    // line geometry
    localparam int LINE_BITS      = 256;
    localparam int WORDS_PER_LINE = 8;
    localparam int WORD_SEL_BITS  = 3;
    localparam int LINE_OFF_BITS  = WORD_SEL_BITS + 2;

    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_BITS   = 3;

    // gselect sizing
    localparam int         PC_IDX_BITS   = 4;
    localparam int         GHR_BITS      = 2;
    localparam int         PRED_IDX_BITS = PC_IDX_BITS + GHR_BITS;
    localparam int         PRED_ENTRIES  = 64;
    localparam logic [1:0] CTR_INIT      = 2'b01;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // same word, two immediate layouts
    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } rv_inst_u;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        pred_taken;
    } fetch_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic        predicted;
    } resolve_t;

    typedef struct packed {
        logic [31:0] addr;
    } line_req_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_ctrl.sv ====
`default_nettype none

module fetch_ctrl (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 hit_i,
    input  wire                 fill_done_i,
    input  wire                 queue_full_i,
    input  fetch_pkg::resolve_t resolve_i,
    output logic                fill_start_o,
    output logic                advance_o,
    output logic                redirect_o,
    output logic                push_o
);

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_FILL,
        S_DRAIN
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   mispredict;

    assign mispredict = resolve_i.valid && (resolve_i.taken != resolve_i.predicted);

    // queue and pc_gen act on this directly
    assign redirect_o = mispredict;

    // hits are served in every state, the buffer line stays good during a fill
    assign push_o    = hit_i && !queue_full_i && !mispredict;
    assign advance_o = push_o;

    // held until the line comes back, the port takes it once idle
    assign fill_start_o = (state_q == S_FILL);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_LOOKUP: begin
                // a miss on a pc about to be replaced is not worth a fill
                if (!hit_i && !mispredict) begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                if (fill_done_i) begin
                    state_d = S_DRAIN;
                end
            end
            S_DRAIN: begin
                // port is still waiting for ack to fall here
                state_d = S_LOOKUP;
            end
            default: begin
                state_d = S_LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/line_buffer.sv ====
`default_nettype none

module line_buffer (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  fill_done_i,
    input  wire  [31:0]                          fill_addr_i,
    input  wire  [fetch_pkg::LINE_BITS-1:0]      line_i,
    input  wire  [31:0]                          pc_i,
    output logic                                 hit_o,
    output fetch_pkg::rv_inst_u                  word_o
);

    logic                                                  valid_q;
    logic [31:fetch_pkg::LINE_OFF_BITS]                    tag_q;
    logic [fetch_pkg::WORDS_PER_LINE-1:0][31:0]            line_q;
    logic [fetch_pkg::WORD_SEL_BITS-1:0]                   word_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fill_done_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done_i) begin
            tag_q  <= fill_addr_i[31:fetch_pkg::LINE_OFF_BITS];
            line_q <= line_i;
        end
    end

    assign word_sel = pc_i[fetch_pkg::LINE_OFF_BITS-1:2];
    assign hit_o    = valid_q && (tag_q == pc_i[31:fetch_pkg::LINE_OFF_BITS]);
    assign word_o   = line_q[word_sel];

endmodule

`default_nettype wire

// ==== verilog/line_fetch_port.sv ====
`default_nettype none

module line_fetch_port (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              start_i,
    input  fetch_pkg::line_req_t             addr_i,
    input  wire                              mem_ack_i,
    input  wire  [fetch_pkg::LINE_BITS-1:0]  mem_line_i,
    output logic                             mem_req_o,
    output logic [31:0]                      mem_addr_o,
    output logic                             fill_done_o,
    output logic [31:0]                      fill_addr_o,
    output logic [fetch_pkg::LINE_BITS-1:0]  line_o
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_REQ,
        P_DROP
    } port_state_e;

    port_state_e state_q;
    logic [31:0] addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= P_IDLE;
            mem_req_o   <= 1'b0;
            fill_done_o <= 1'b0;
        end else begin
            fill_done_o <= 1'b0;
            case (state_q)
                P_IDLE: begin
                    if (start_i) begin
                        mem_req_o <= 1'b1;
                        state_q   <= P_REQ;
                    end
                end
                P_REQ: begin
                    if (mem_ack_i) begin
                        mem_req_o   <= 1'b0;
                        fill_done_o <= 1'b1;
                        state_q     <= P_DROP;
                    end
                end
                P_DROP: begin
                    // wait out the responder's ack before the next req
                    if (!mem_ack_i) begin
                        state_q <= P_IDLE;
                    end
                end
                default: begin
                    state_q <= P_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == P_IDLE && start_i) begin
            addr_q <= {addr_i.addr[31:fetch_pkg::LINE_OFF_BITS],
                       {fetch_pkg::LINE_OFF_BITS{1'b0}}};
        end
        // first ack cycle only
        if (state_q == P_REQ && mem_ack_i) begin
            line_o <= mem_line_i;
        end
    end

    assign mem_addr_o  = addr_q;
    assign fill_addr_o = addr_q;

endmodule

`default_nettype wire

// ==== verilog/pc_gen.sv ====
`default_nettype none

module pc_gen (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     advance_i,
    input  wire                     redirect_i,
    input  fetch_pkg::resolve_t     resolve_i,
    input  fetch_pkg::rv_inst_u     word_i,
    input  wire                     pred_taken_i,
    output logic [31:0]             pc_o,
    output fetch_pkg::fetch_entry_t entry_o
);

    logic [31:0] pc_q;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm;
    logic [31:0] next_pc;
    logic [31:0] redirect_pc;
    logic        is_branch;
    logic        is_jal;
    logic        steer;

    // B and J immediates from the same word
    assign imm_b = {{19{word_i.b.imm12}}, word_i.b.imm12, word_i.b.imm11,
                    word_i.b.imm10_5, word_i.b.imm4_1, 1'b0};
    assign imm_j = {{11{word_i.j.imm20}}, word_i.j.imm20, word_i.j.imm19_12,
                    word_i.j.imm11, word_i.j.imm10_1, 1'b0};

    assign is_branch = (word_i.b.opcode == fetch_pkg::OPC_BRANCH);
    assign is_jal    = (word_i.j.opcode == fetch_pkg::OPC_JAL);
    assign steer     = pred_taken_i && (is_branch || is_jal);
    assign imm       = is_jal ? imm_j : imm_b;
    assign next_pc   = steer ? (pc_q + imm) : (pc_q + 32'd4);

    assign redirect_pc = resolve_i.taken ? resolve_i.target : (resolve_i.pc + 32'd4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc;
        end else if (advance_i) begin
            pc_q <= next_pc;
        end
    end

    assign pc_o             = pc_q;
    assign entry_o.pc         = pc_q;
    assign entry_o.inst       = word_i;
    assign entry_o.pred_taken = steer;

endmodule

`default_nettype wire

// ==== verilog/gselect_predictor.sv ====
`default_nettype none

module gselect_predictor (
    input  wire                 clk,
    input  wire                 rst,
    input  wire  [31:0]         pc_i,
    input  fetch_pkg::resolve_t resolve_i,
    output logic                taken_o
);

    logic [1:0]                              ctr_q [fetch_pkg::PRED_ENTRIES];
    logic [fetch_pkg::GHR_BITS-1:0]          ghr_q;
    logic [fetch_pkg::PRED_IDX_BITS-1:0]     pred_idx;
    logic [fetch_pkg::PRED_IDX_BITS-1:0]     upd_idx;
    logic [1:0]                              upd_ctr;

    assign pred_idx = {pc_i[fetch_pkg::PC_IDX_BITS+1:2], ghr_q};
    assign upd_idx  = {resolve_i.pc[fetch_pkg::PC_IDX_BITS+1:2], ghr_q};
    assign taken_o  = ctr_q[pred_idx][1];

    // saturating step toward the outcome
    always_comb begin
        upd_ctr = ctr_q[upd_idx];
        if (resolve_i.taken) begin
            if (upd_ctr != 2'b11) begin
                upd_ctr = upd_ctr + 2'b01;
            end
        end else if (upd_ctr != 2'b00) begin
            upd_ctr = upd_ctr - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fetch_pkg::PRED_ENTRIES; i++) begin
                ctr_q[i] <= fetch_pkg::CTR_INIT;
            end
            ghr_q <= '0;
        end else if (resolve_i.valid) begin
            ctr_q[upd_idx] <= upd_ctr;
            ghr_q          <= {ghr_q[fetch_pkg::GHR_BITS-2:0], resolve_i.taken};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_queue.sv ====
`default_nettype none

module fetch_queue (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush_i,
    input  wire                     push_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    input  wire                     pop_i,
    output logic                    full_o,
    output logic                    valid_o,
    output fetch_pkg::fetch_entry_t head_o
);

    fetch_pkg::fetch_entry_t          mem_q [fetch_pkg::QUEUE_DEPTH];
    logic [fetch_pkg::QPTR_BITS-1:0]  head_q;
    logic [fetch_pkg::QPTR_BITS-1:0]  tail_q;
    logic [fetch_pkg::QPTR_BITS:0]    count_q;
    logic                             do_push;
    logic                             do_pop;

    // depth is a power of two, so the top count bit means full
    assign full_o  = count_q[fetch_pkg::QPTR_BITS];
    assign valid_o = (count_q != '0);
    assign head_o  = mem_q[head_q];

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_pop) begin
                head_q <= head_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[tail_q] <= entry_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`default_nettype none

module fetch_top (
    input  wire                              clk,
    input  wire                              rst,
    output logic                             mem_req_o,
    output logic [31:0]                      mem_addr_o,
    input  wire                              mem_ack_i,
    input  wire  [fetch_pkg::LINE_BITS-1:0]  mem_line_i,
    input  fetch_pkg::resolve_t              resolve_i,
    output logic                             inst_valid_o,
    output fetch_pkg::fetch_entry_t          inst_o,
    input  wire                              inst_take_i
);

    logic                            hit;
    logic                            fill_done;
    logic                            fill_start;
    logic                            queue_full;
    logic                            advance;
    logic                            redirect;
    logic                            push;
    logic                            pred_taken;
    logic [31:0]                     pc;
    logic [31:0]                     fill_addr;
    logic [fetch_pkg::LINE_BITS-1:0] fill_line;
    fetch_pkg::rv_inst_u             word;
    fetch_pkg::fetch_entry_t         entry;

    fetch_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .hit_i        (hit),
        .fill_done_i  (fill_done),
        .queue_full_i (queue_full),
        .resolve_i    (resolve_i),
        .fill_start_o (fill_start),
        .advance_o    (advance),
        .redirect_o   (redirect),
        .push_o       (push)
    );

    line_buffer i_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .fill_done_i (fill_done),
        .fill_addr_i (fill_addr),
        .line_i      (fill_line),
        .pc_i        (pc),
        .hit_o       (hit),
        .word_o      (word)
    );

    // port aligns the pc to its line
    line_fetch_port i_fetch_port (
        .clk         (clk),
        .rst         (rst),
        .start_i     (fill_start),
        .addr_i      (fetch_pkg::line_req_t'(pc)),
        .mem_ack_i   (mem_ack_i),
        .mem_line_i  (mem_line_i),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .fill_done_o (fill_done),
        .fill_addr_o (fill_addr),
        .line_o      (fill_line)
    );

    pc_gen i_pc_gen (
        .clk          (clk),
        .rst          (rst),
        .advance_i    (advance),
        .redirect_i   (redirect),
        .resolve_i    (resolve_i),
        .word_i       (word),
        .pred_taken_i (pred_taken),
        .pc_o         (pc),
        .entry_o      (entry)
    );

    gselect_predictor i_predictor (
        .clk       (clk),
        .rst       (rst),
        .pc_i      (pc),
        .resolve_i (resolve_i),
        .taken_o   (pred_taken)
    );

    fetch_queue i_queue (
        .clk     (clk),
        .rst     (rst),
        .flush_i (redirect),
        .push_i  (push),
        .entry_i (entry),
        .pop_i   (inst_take_i),
        .full_o  (queue_full),
        .valid_o (inst_valid_o),
        .head_o  (inst_o)
    );

endmodule

`default_nettype wire

// ==== verification/fetch_props.sv ====
`default_nettype none

module fetch_props (
    input wire        clk,
    input wire        rst,
    input wire        mem_req_o,
    input wire [31:0] mem_addr_o,
    input wire        mem_ack_i,
    input wire        inst_valid_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
        else begin
            fail_count++;
            $error("req or addr changed before ack");
        end

    a_no_req_in_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req_o) |-> !mem_ack_i)
        else begin
            fail_count++;
            $error("req raised while ack still high");
        end

    a_empty_after_rst: assert property (@(posedge clk) rst |=> !inst_valid_o)
        else begin
            fail_count++;
            $error("inst_valid_o high right after reset");
        end

endmodule

bind fetch_top fetch_props i_props (
    .clk          (clk),
    .rst          (rst),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_ack_i    (mem_ack_i),
    .inst_valid_o (inst_valid_o)
);

`default_nettype wire

// ==== verification/tb_fetch.sv ====
`default_nettype none

module tb_fetch;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED       = 32'hf7c19e0c;
    localparam logic [31:0] NOP_WORD   = 32'h00000013;
    localparam int          WAIT_LIMIT = 1000;

    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic [31:0] count;
    } vec_cmd_t;

    logic                            clk;
    logic                            rst;
    logic                            mem_req;
    logic [31:0]                     mem_addr;
    logic                            mem_ack;
    logic [fetch_pkg::LINE_BITS-1:0] mem_line;
    fetch_pkg::resolve_t             resolve;
    logic                            inst_valid;
    fetch_pkg::fetch_entry_t         inst;
    logic                            inst_take;

    logic [31:0] mem_words [logic [31:0]];
    vec_cmd_t    cmds [$];
    logic [1:0]  model_ctr [fetch_pkg::PRED_ENTRIES];
    logic [1:0]  model_ghr;
    logic [31:0] model_pc;
    logic [31:0] take_rng;
    logic [31:0] resp_rng;

    fetch_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_ack_i    (mem_ack),
        .mem_line_i   (mem_line),
        .resolve_i    (resolve),
        .inst_valid_o (inst_valid),
        .inst_o       (inst),
        .inst_take_i  (inst_take)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return NOP_WORD;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_entry(input string name, input fetch_pkg::fetch_entry_t exp,
                               input fetch_pkg::fetch_entry_t act);
        if (act !== exp) begin
            report_failure($sformatf(
                "FAIL %s expected pc=%h inst=%h pred=%b actual pc=%h inst=%h pred=%b",
                name, exp.pc, exp.inst, exp.pred_taken, act.pc, act.inst, act.pred_taken));
        end
    endtask

    task automatic check_line_addr(input string name, input fetch_pkg::line_req_t exp,
                                   input fetch_pkg::line_req_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAIL %s expected addr=%h actual addr=%h",
                                     name, exp.addr, act.addr));
        end
    endtask

    // RV32I immediates, J-type for jal and B-type otherwise
    function automatic logic [31:0] ctl_imm(input logic [31:0] w);
        if (w[6:0] == fetch_pkg::OPC_JAL) begin
            return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic fetch_pkg::fetch_entry_t model_entry();
        fetch_pkg::fetch_entry_t e;
        logic                    is_ctl;
        e.pc   = model_pc;
        e.inst = read_word(model_pc);
        is_ctl = (e.inst[6:0] == fetch_pkg::OPC_BRANCH) || (e.inst[6:0] == fetch_pkg::OPC_JAL);
        e.pred_taken = is_ctl && model_ctr[{model_pc[5:2], model_ghr}][1];
        return e;
    endfunction

    task automatic model_resolve(input vec_cmd_t c);
        logic [5:0] idx;
        idx = {c.pc[5:2], model_ghr};
        if (c.taken && model_ctr[idx] != 2'b11) begin
            model_ctr[idx] = model_ctr[idx] + 2'b01;
        end else if (!c.taken && model_ctr[idx] != 2'b00) begin
            model_ctr[idx] = model_ctr[idx] - 2'b01;
        end
        model_ghr = {model_ghr[0], c.taken};
        model_pc  = c.taken ? c.target : c.pc + 32'd4;
    endtask

    task automatic load_vectors();
        int          fd;
        string       text;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        vec_cmd_t    c;
        fd = $fopen("verification/fetch_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verification/fetch_vectors.txt");
        end
        while ($fgets(text, fd) > 0) begin
            c = '0;
            if (text.len() == 0 || text.getc(0) == "#") begin
                continue;
            end
            if ($sscanf(text, "m %h %h", a, d) == 2) begin
                mem_words[a] = d;
            end else if ($sscanf(text, "r %h %h %h", a, b, d) == 3) begin
                c.kind   = "r";
                c.pc     = a;
                c.taken  = b[0];
                c.target = d;
                cmds.push_back(c);
            end else if ($sscanf(text, "t %d", a) == 1) begin
                c.kind  = "t";
                c.count = a;
                cmds.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // every resolve in the vectors is a mispredict
    task automatic apply_resolve(input vec_cmd_t c);
        fetch_pkg::resolve_t r;
        r.valid     = 1'b1;
        r.pc        = c.pc;
        r.taken     = c.taken;
        r.target    = c.target;
        r.predicted = !c.taken;
        @(posedge clk);
        resolve <= r;
        @(posedge clk);
        resolve <= '0;
        model_resolve(c);
    endtask

    task automatic take_entries(input int n, input int block);
        int                      got;
        int                      gap;
        int                      waited;
        fetch_pkg::fetch_entry_t e;
        got = 0;
        while (got < n) begin
            take_rng = xorshift32(take_rng);
            gap = int'(take_rng % 4);
            // long stall lets the queue fill up
            if (take_rng[31:29] == 3'b000) begin
                gap = 20;
            end
            repeat (gap) begin
                @(posedge clk);
                inst_take <= 1'b0;
            end
            @(posedge clk);
            inst_take <= 1'b1;
            waited = 0;
            @(negedge clk);
            while (!inst_valid) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_failure($sformatf("no entry arrived in take block %0d", block));
                end
                @(negedge clk);
            end
            e = model_entry();
            check_entry($sformatf("take block %0d entry %0d", block, got), e, inst);
            model_pc = e.pred_taken ? e.pc + ctl_imm(e.inst) : e.pc + 32'd4;
            got++;
        end
        @(posedge clk);
        inst_take <= 1'b0;
    endtask

    // memory responder, four-phase slave
    initial begin
        int                              waited;
        int                              delay;
        fetch_pkg::line_req_t            seen;
        fetch_pkg::line_req_t            aligned;
        logic [fetch_pkg::LINE_BITS-1:0] fill;
        mem_ack  <= 1'b0;
        mem_line <= '0;
        resp_rng = xorshift32(SEED);
        forever begin
            waited = 0;
            @(negedge clk);
            while (!mem_req) begin
                waited++;
                if (waited > 4 * WAIT_LIMIT) begin
                    report_failure("the DUT raised no line request");
                end
                @(negedge clk);
            end
            seen.addr    = mem_addr;
            aligned.addr = mem_addr & ~32'h1f;
            check_line_addr("fill address", aligned, seen);
            for (int w = 0; w < fetch_pkg::WORDS_PER_LINE; w++) begin
                fill[32*w +: 32] = read_word(aligned.addr + 32'(4 * w));
            end
            resp_rng = xorshift32(resp_rng);
            delay = int'(resp_rng % 6);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            mem_ack  <= 1'b1;
            mem_line <= fill;
            waited = 0;
            @(negedge clk);
            while (mem_req) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_failure("the DUT held req high after ack");
                end
                @(negedge clk);
            end
            @(posedge clk);
            mem_ack  <= 1'b0;
            mem_line <= '0;
        end
    end

    initial begin
        rst       <= 1'b1;
        resolve   <= '0;
        inst_take <= 1'b0;
        model_pc  = fetch_pkg::RESET_PC;
        model_ghr = '0;
        for (int i = 0; i < fetch_pkg::PRED_ENTRIES; i++) begin
            model_ctr[i] = fetch_pkg::CTR_INIT;
        end
        take_rng = SEED;
        load_vectors();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        foreach (cmds[i]) begin
            if (cmds[i].kind == "r") begin
                apply_resolve(cmds[i]);
            end else begin
                take_entries(int'(cmds[i].count), i);
            end
        end
        repeat (4) @(posedge clk);
        if (i_dut.i_props.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_failure("concurrent assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== verification/fetch_vectors.txt ====
# m <addr> <word>: memory word; r <pc> <taken> <target>: mispredicted resolve
# t <count>: take that many entries and check each one
m aaaaa020 02000063
m aaaaa044 0100006f
t 24
r aaaaa020 1 aaaaa040
t 4
r aaaaa044 1 aaaaa054
t 4
r aaaaa020 1 aaaaa040
r aaaaa000 1 aaaaa018
t 6
r aaaaa044 1 aaaaa054
t 3
r aaaaa000 1 aaaaa03c
t 4
r aaaaa100 0 00000000
t 20

// ==== verilog.f ====
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/line_buffer.sv
verilog/line_fetch_port.sv
verilog/pc_gen.sv
verilog/gselect_predictor.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
verification/fetch_props.sv
verification/tb_fetch.sv
